// ==== include/fpsu_defs.svh ====
`ifndef FPSU_DEFS_SVH
`define FPSU_DEFS_SVH

// operand word layout: tag, high half, low half
`define FPSU_WORD_W 68
`define FPSU_HALF_W 33
`define FPSU_HI_LSB 33
`define FPSU_TAG_LSB 66

`define FPSU_OP_W 3
`define FPSU_MOD_W 3

// opcodes, 6 and 7 unused
`define FPSU_OP_AND 3'd0
`define FPSU_OP_OR 3'd1
`define FPSU_OP_XOR 3'd2
`define FPSU_OP_ANDN 3'd3
`define FPSU_OP_PERM 3'd4
`define FPSU_OP_CMP 3'd5

// permute modifiers
`define FPSU_PERM_COPY 3'd0
`define FPSU_PERM_SWAP 3'd1
`define FPSU_PERM_DUP 3'd2
`define FPSU_PERM_MERGE 3'd3

// compare relation in mod[1:0], ordered select in mod[2]
`define FPSU_CMP_EQ 2'd0
`define FPSU_CMP_LT 2'd1
`define FPSU_CMP_LE 2'd2
`define FPSU_CMP_ORD_BIT 2

`define FPSU_CSR_INV_TRAP 5

`endif

// ==== logic/fpsu_pkg.sv ====
`include "fpsu_defs.svh"

package fpsu_pkg;

  typedef logic [`FPSU_WORD_W-1:0] fpsu_word_t;

  // relation flags of the low half
  typedef struct packed {
    logic unord;
    logic gt;
    logic eq;
    logic lt;
  } fpsu_flags_t;

  typedef struct packed {
    logic en;
    logic [`FPSU_OP_W-1:0] op;
    logic [`FPSU_MOD_W-1:0] mod;
    fpsu_word_t a;
    fpsu_word_t b;
    logic fwd_a;
    logic fwd_b;
  } fpsu_issue_t;

  // operands already resolved, op known to be legal when valid
  typedef struct packed {
    logic valid;
    logic [`FPSU_OP_W-1:0] op;
    logic [`FPSU_MOD_W-1:0] mod;
    fpsu_word_t a;
    fpsu_word_t b;
  } fpsu_exec_t;

  typedef struct packed {
    logic valid;
    fpsu_word_t data;
    fpsu_flags_t flags;
    // invalid raised, bit 1 high half, bit 0 low half
    logic [1:0] raise;
  } fpsu_result_t;

endpackage

// ==== logic/fpsu_issue_stage.sv ====
`timescale 1ns/10ps

module fpsu_issue_stage
  import fpsu_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  fpsu_issue_t issue,
  output fpsu_issue_t staged
);

  // request register
  always_ff @(posedge clk) begin
    if (rst) begin
      staged <= '0;
    end else if (issue.en) begin
      staged <= issue;
    end else begin
      // idle cycle, operands held
      staged.en <= 1'b0;
    end
  end

endmodule

// ==== logic/fpsu_operand_stage.sv ====
`timescale 1ns/10ps
`include "fpsu_defs.svh"

module fpsu_operand_stage
  import fpsu_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  fpsu_issue_t staged,
  input  fpsu_word_t  fwd_data,
  output fpsu_exec_t  exec
);

  fpsu_word_t op_a;
  fpsu_word_t op_b;
  logic       op_ok;

  // forwarding from the unit's own result register
  assign op_a = staged.fwd_a ? fwd_data : staged.a;
  assign op_b = staged.fwd_b ? fwd_data : staged.b;

  // opcode decode
  always_comb begin
    case (staged.op)
      `FPSU_OP_AND,
      `FPSU_OP_OR,
      `FPSU_OP_XOR,
      `FPSU_OP_ANDN,
      `FPSU_OP_PERM,
      `FPSU_OP_CMP: op_ok = 1'b1;
      default: op_ok = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    exec.op  <= staged.op;
    exec.mod <= staged.mod;
    exec.a   <= op_a;
    exec.b   <= op_b;
    // unknown opcode becomes a bubble
    if (rst) begin
      exec.valid <= 1'b0;
    end else begin
      exec.valid <= staged.en & op_ok;
    end
  end

endmodule

// ==== logic/fpsu_compare.sv ====
`timescale 1ns/10ps
`include "fpsu_defs.svh"

module fpsu_compare
  import fpsu_pkg::*;
(
  input  fpsu_word_t             a,
  input  fpsu_word_t             b,
  input  logic [`FPSU_MOD_W-1:0] mod,
  output fpsu_word_t             mask,
  output fpsu_flags_t            flags,
  output logic [1:0]             raise
);

  logic [1:0] unord;
  logic [1:0] eq;
  logic [1:0] lt;
  logic [1:0] gt;

  for (genvar h = 0; h < 2; h++) begin : g_half
    localparam int LSB = h * `FPSU_HI_LSB;

    logic [31:0] x;
    logic [31:0] y;
    logic        x_nan;
    logic        y_nan;
    logic        both_zero;
    logic        rel;

    assign x = a[LSB +: 32];
    assign y = b[LSB +: 32];
    assign x_nan = (x[30:23] == 8'hff) && (x[22:0] != '0);
    assign y_nan = (y[30:23] == 8'hff) && (y[22:0] != '0);
    // +0 and -0 compare equal
    assign both_zero = (x[30:0] == '0) && (y[30:0] == '0);

    assign unord[h] = x_nan | y_nan;
    assign eq[h] = ~unord[h] & (both_zero | (x == y));

    // sign-magnitude ordering
    always_comb begin
      lt[h] = 1'b0;
      gt[h] = 1'b0;
      if (!unord[h] && !both_zero) begin
        if (x[31] != y[31]) begin
          lt[h] = x[31];
          gt[h] = y[31];
        end else if (x[31]) begin
          lt[h] = x[30:0] > y[30:0];
          gt[h] = x[30:0] < y[30:0];
        end else begin
          lt[h] = x[30:0] < y[30:0];
          gt[h] = x[30:0] > y[30:0];
        end
      end
    end

    always_comb begin
      case (mod[1:0])
        `FPSU_CMP_EQ: rel = eq[h];
        `FPSU_CMP_LT: rel = lt[h];
        `FPSU_CMP_LE: rel = lt[h] | eq[h];
        default: rel = 1'b0;
      endcase
    end

    assign mask[LSB +: `FPSU_HALF_W] = {`FPSU_HALF_W{rel}};
    assign raise[h] = mod[`FPSU_CMP_ORD_BIT] & unord[h];
  end

  assign mask[`FPSU_WORD_W-1:`FPSU_TAG_LSB] = '0;

  // low half only
  assign flags = '{unord: unord[0], gt: gt[0], eq: eq[0], lt: lt[0]};

endmodule

// ==== logic/fpsu_execute_stage.sv ====
`timescale 1ns/10ps
`include "fpsu_defs.svh"

module fpsu_execute_stage
  import fpsu_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  fpsu_exec_t   exec,
  input  logic [31:0]  fpcsr,
  output fpsu_result_t result,
  output logic [1:0]   ret,
  output logic         ret_en
);

  fpsu_word_t  perm_res;
  fpsu_word_t  data_nxt;
  fpsu_word_t  cmp_mask;
  fpsu_flags_t cmp_flags;
  logic [1:0]  cmp_raise;
  logic        is_cmp;

  logic [`FPSU_WORD_W-`FPSU_TAG_LSB-1:0] a_tag;
  logic [`FPSU_HALF_W-1:0]               a_hi;
  logic [`FPSU_HALF_W-1:0]               a_lo;
  logic [`FPSU_HALF_W-1:0]               b_lo;

  assign a_tag = exec.a[`FPSU_WORD_W-1:`FPSU_TAG_LSB];
  assign a_hi  = exec.a[`FPSU_TAG_LSB-1:`FPSU_HI_LSB];
  assign a_lo  = exec.a[`FPSU_HALF_W-1:0];
  assign b_lo  = exec.b[`FPSU_HALF_W-1:0];

  fpsu_compare fpsu_compare_inst (
    .a     (exec.a),
    .b     (exec.b),
    .mod   (exec.mod),
    .mask  (cmp_mask),
    .flags (cmp_flags),
    .raise (cmp_raise)
  );

  // tag always from a
  always_comb begin
    case (exec.mod)
      `FPSU_PERM_SWAP: perm_res = {a_tag, a_lo, a_hi};
      `FPSU_PERM_DUP: perm_res = {a_tag, a_lo, a_lo};
      `FPSU_PERM_MERGE: perm_res = {a_tag, a_hi, b_lo};
      default: perm_res = exec.a;
    endcase
  end

  always_comb begin
    case (exec.op)
      `FPSU_OP_AND: data_nxt = exec.a & exec.b;
      `FPSU_OP_OR: data_nxt = exec.a | exec.b;
      `FPSU_OP_XOR: data_nxt = exec.a ^ exec.b;
      `FPSU_OP_ANDN: data_nxt = exec.a & ~exec.b;
      `FPSU_OP_PERM: data_nxt = perm_res;
      default: data_nxt = cmp_mask;
    endcase
  end

  assign is_cmp = exec.op == `FPSU_OP_CMP;

  // data of the last valid item is the forwarding source
  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
    end else if (exec.valid) begin
      result.valid <= 1'b1;
      result.data  <= data_nxt;
      result.flags <= is_cmp ? cmp_flags : '0;
      result.raise <= is_cmp ? cmp_raise : 2'b00;
    end else begin
      result.valid <= 1'b0;
      result.flags <= '0;
    end
  end

  // invalid trap report
  assign ret_en = result.valid & (|result.raise) & fpcsr[`FPSU_CSR_INV_TRAP];
  assign ret    = ret_en ? result.raise : 2'b00;

endmodule

// ==== logic/fpsu_top.sv ====
`timescale 1ns/10ps

module fpsu_top
  import fpsu_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] fpcsr,
  input  fpsu_issue_t issue,
  output fpsu_word_t  res_data,
  output logic        res_valid,
  output fpsu_flags_t cmp_flags,
  output logic [1:0]  ret,
  output logic        ret_en
);

  fpsu_issue_t  staged;
  fpsu_exec_t   exec;
  fpsu_result_t result;

  fpsu_issue_stage fpsu_issue_stage_inst (
    .clk    (clk),
    .rst    (rst),
    .issue  (issue),
    .staged (staged)
  );

  // result data loops back for forwarding
  fpsu_operand_stage fpsu_operand_stage_inst (
    .clk      (clk),
    .rst      (rst),
    .staged   (staged),
    .fwd_data (result.data),
    .exec     (exec)
  );

  fpsu_execute_stage fpsu_execute_stage_inst (
    .clk    (clk),
    .rst    (rst),
    .exec   (exec),
    .fpcsr  (fpcsr),
    .result (result),
    .ret    (ret),
    .ret_en (ret_en)
  );

  assign res_data  = result.data;
  assign res_valid = result.valid;
  assign cmp_flags = result.flags;

endmodule

// ==== bench/fpsu_tb.sv ====
`timescale 1ns/10ps
`include "fpsu_defs.svh"

module fpsu_tb
  import fpsu_pkg::*;
;

  logic        clk;
  logic        rst;
  logic [31:0] fpcsr;
  fpsu_issue_t issue;
  fpsu_word_t  res_data;
  logic        res_valid;
  fpsu_flags_t cmp_flags;
  logic [1:0]  ret;
  logic        ret_en;

  fpsu_top fpsu_top_inst (
    .clk       (clk),
    .rst       (rst),
    .fpcsr     (fpcsr),
    .issue     (issue),
    .res_data  (res_data),
    .res_valid (res_valid),
    .cmp_flags (cmp_flags),
    .ret       (ret),
    .ret_en    (ret_en)
  );

  // stimulus table
  fpsu_issue_t tbl_req [64];
  logic [31:0] tbl_csr [64];
  string       tbl_name [64];
  int          nrows;

  // expected items in flight
  logic        q_valid [$];
  fpsu_word_t  q_data [$];
  fpsu_flags_t q_flags [$];
  logic [1:0]  q_raise [$];
  string       q_name [$];

  // model of the result register and the two items ahead of it
  fpsu_word_t fwd_reg;
  logic       d1_valid;
  logic       d2_valid;
  fpsu_word_t d1_data;
  fpsu_word_t d2_data;

  int mismatches;
  int other_errors;
  int cycles;
  int limit;
  int seed;

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("Some tests failed");
      $finish;
    end
  end

  function automatic fpsu_word_t rand_word();
    logic [95:0] r;
    r = {$random(seed), $random(seed), $random(seed)};
    return r[67:0];
  endfunction

  function automatic fpsu_word_t pack_singles(logic [1:0] tag, logic [31:0] hi, logic [31:0] lo);
    return {tag, 1'b0, hi, 1'b0, lo};
  endfunction

  task automatic add_row(string name, logic en, logic [2:0] op, logic [2:0] mod,
                         fpsu_word_t a, fpsu_word_t b, logic fa, logic fb,
                         logic [31:0] csr);
    tbl_req[nrows] = '{en: en, op: op, mod: mod, a: a, b: b, fwd_a: fa, fwd_b: fb};
    tbl_csr[nrows] = csr;
    tbl_name[nrows] = name;
    nrows++;
  endtask

  // single to real, rebuilt as a double
  function automatic real single_to_real(logic [31:0] s);
    logic [10:0] e;
    real         r;
    if (s[30:23] == 8'h00) begin
      // subnormal, mantissa times 2^-149
      r = s[22:0];
      r = r * $bitstoreal({1'b0, 11'd874, 52'b0});
      return s[31] ? -r : r;
    end
    e = {3'b000, s[30:23]} + 11'd896;
    return $bitstoreal({s[31], e, s[22:0], 29'b0});
  endfunction

  // reference compare per half
  task automatic model_compare(fpsu_word_t a, fpsu_word_t b, logic [2:0] mod,
                               output fpsu_word_t m, output fpsu_flags_t f,
                               output logic [1:0] r);
    logic [31:0] x;
    logic [31:0] y;
    logic        un;
    logic        eq;
    logic        lt;
    logic        gt;
    logic        rel;
    real         rx;
    real         ry;
    m = '0;
    f = '0;
    for (int h = 0; h < 2; h++) begin
      x = a[h*33 +: 32];
      y = b[h*33 +: 32];
      un = (x[30:23] == 8'hff && x[22:0] != 0) || (y[30:23] == 8'hff && y[22:0] != 0);
      rx = single_to_real(x);
      ry = single_to_real(y);
      eq = !un && (rx == ry);
      lt = !un && (rx < ry);
      gt = !un && (rx > ry);
      case (mod[1:0])
        2'd0: rel = eq;
        2'd1: rel = lt;
        2'd2: rel = lt | eq;
        default: rel = 1'b0;
      endcase
      m[h*33 +: 33] = {33{rel}};
      r[h] = mod[2] & un;
      if (h == 0) f = '{unord: un, gt: gt, eq: eq, lt: lt};
    end
  endtask

  task automatic run_row(fpsu_issue_t req, logic [31:0] csr, string name);
    fpsu_word_t  a;
    fpsu_word_t  b;
    fpsu_word_t  d;
    fpsu_flags_t f;
    logic [1:0]  r;
    logic        v;
    logic        exp_ret_en;
    string       exp_name;
    @(posedge clk);
    #1;
    issue = req;
    fpcsr = csr;
    if (d2_valid) fwd_reg = d2_data;
    a = req.fwd_a ? fwd_reg : req.a;
    b = req.fwd_b ? fwd_reg : req.b;
    v = req.en && req.op <= 3'd5;
    f = '0;
    r = 2'b00;
    case (req.op)
      3'd0: d = a & b;
      3'd1: d = a | b;
      3'd2: d = a ^ b;
      3'd3: d = a & ~b;
      3'd4: begin
        case (req.mod)
          3'd1: d = {a[67:66], a[32:0], a[65:33]};
          3'd2: d = {a[67:66], a[32:0], a[32:0]};
          3'd3: d = {a[67:66], a[65:33], b[32:0]};
          default: d = a;
        endcase
      end
      default: model_compare(a, b, req.mod, d, f, r);
    endcase
    d2_valid = d1_valid;
    d2_data = d1_data;
    d1_valid = v;
    d1_data = d;
    q_valid.push_back(v);
    q_data.push_back(d);
    q_flags.push_back(f);
    q_raise.push_back(r);
    q_name.push_back(name);
    #1;
    if (q_valid.size() == 4) begin
      v = q_valid.pop_front();
      d = q_data.pop_front();
      f = q_flags.pop_front();
      r = q_raise.pop_front();
      exp_name = q_name.pop_front();
      if (v) begin
        exp_ret_en = (r != 2'b00) && fpcsr[`FPSU_CSR_INV_TRAP];
        if (res_valid !== 1'b1) begin
          $display("%s: result missing, res_valid is low", exp_name);
          other_errors++;
        end
        if (res_data !== d) begin
          $display("MISMATCH %s res_data exp %h got %h", exp_name, d, res_data);
          mismatches++;
        end
        if (cmp_flags !== f) begin
          $display("MISMATCH %s cmp_flags exp %b got %b", exp_name, f, cmp_flags);
          mismatches++;
        end
        if (ret_en !== exp_ret_en) begin
          $display("MISMATCH %s ret_en exp %b got %b", exp_name, exp_ret_en, ret_en);
          mismatches++;
        end
        if (ret !== (exp_ret_en ? r : 2'b00)) begin
          $display("MISMATCH %s ret exp %b got %b", exp_name, exp_ret_en ? r : 2'b00, ret);
          mismatches++;
        end
      end else if (res_valid !== 1'b0 || ret_en !== 1'b0 || cmp_flags !== '0) begin
        $display("%s: res_valid, ret_en or cmp_flags high with no result expected", exp_name);
        other_errors++;
      end
    end else if (res_valid !== 1'b0) begin
      $display("%s: res_valid high with no expected item", name);
      other_errors++;
    end
  endtask

  initial begin
    logic [31:0] qnan;
    fpsu_issue_t idle;
    seed = 68;
    clk = 1'b0;
    rst = 1'b1;
    fpcsr = '0;
    issue = '0;
    idle = '0;
    nrows = 0;
    cycles = 0;
    mismatches = 0;
    other_errors = 0;
    fwd_reg = '0;
    d1_valid = 1'b0;
    d2_valid = 1'b0;
    d1_data = '0;
    d2_data = '0;
    qnan = 32'h7fc0_0001;

    add_row("idle", 0, 0, 0, rand_word(), rand_word(), 0, 0, 32'h20);
    add_row("and", 1, `FPSU_OP_AND, 0, rand_word(), rand_word(), 0, 0, 32'h20);
    add_row("or", 1, `FPSU_OP_OR, 0, rand_word(), rand_word(), 0, 0, 32'h20);
    add_row("xor", 1, `FPSU_OP_XOR, 0, rand_word(), rand_word(), 0, 0, 32'h20);
    add_row("andn", 1, `FPSU_OP_ANDN, 0, rand_word(), rand_word(), 0, 0, 32'h20);
    add_row("bad_op", 1, 3'd6, 0, rand_word(), rand_word(), 0, 0, 32'h20);
    add_row("perm_copy", 1, `FPSU_OP_PERM, `FPSU_PERM_COPY, rand_word(), rand_word(), 0, 0, 32'h20);
    add_row("perm_swap", 1, `FPSU_OP_PERM, `FPSU_PERM_SWAP, rand_word(), rand_word(), 0, 0, 32'h20);
    add_row("perm_dup", 1, `FPSU_OP_PERM, `FPSU_PERM_DUP, rand_word(), rand_word(), 0, 0, 32'h20);
    add_row("perm_merge", 1, `FPSU_OP_PERM, `FPSU_PERM_MERGE, rand_word(), rand_word(), 0, 0, 32'h20);
    // 1.5 vs 1.5 low, -2.0 vs 3.0 high
    add_row("cmp_eq", 1, `FPSU_OP_CMP, {1'b0, `FPSU_CMP_EQ},
            pack_singles(2'b11, 32'hc000_0000, 32'h3fc0_0000),
            pack_singles(2'b01, 32'h4040_0000, 32'h3fc0_0000), 0, 0, 32'h20);
    add_row("cmp_lt", 1, `FPSU_OP_CMP, {1'b0, `FPSU_CMP_LT},
            pack_singles(2'b00, 32'hc000_0000, 32'h4040_0000),
            pack_singles(2'b00, 32'h4040_0000, 32'hbf80_0000), 0, 0, 32'h20);
    add_row("cmp_le", 1, `FPSU_OP_CMP, {1'b0, `FPSU_CMP_LE},
            pack_singles(2'b00, 32'hc080_0000, 32'h3fc0_0000),
            pack_singles(2'b00, 32'hc000_0000, 32'h3fc0_0000), 0, 0, 32'h20);
    add_row("cmp_zero", 1, `FPSU_OP_CMP, {1'b0, `FPSU_CMP_EQ},
            pack_singles(2'b00, 32'h8000_0000, 32'h0000_0000),
            pack_singles(2'b00, 32'h0000_0000, 32'h8000_0000), 0, 0, 32'h20);
    add_row("cmp_nan_unord", 1, `FPSU_OP_CMP, {1'b0, `FPSU_CMP_LE},
            pack_singles(2'b00, 32'h3f80_0000, qnan),
            pack_singles(2'b00, 32'h3f80_0000, 32'h3f80_0000), 0, 0, 32'h20);
    // only the low half is unordered
    add_row("cmp_nan_ord", 1, `FPSU_OP_CMP, {1'b1, `FPSU_CMP_EQ},
            pack_singles(2'b00, 32'h3f80_0000, 32'h3f80_0000),
            pack_singles(2'b00, 32'h3f80_0000, 32'h7f80_0100), 0, 0, 32'h20);
    add_row("idle", 0, 0, 0, rand_word(), rand_word(), 0, 0, 32'h20);
    add_row("idle", 0, 0, 0, rand_word(), rand_word(), 0, 0, 32'h20);
    add_row("idle", 0, 0, 0, rand_word(), rand_word(), 0, 0, 32'h20);
    add_row("cmp_nan_notrap", 1, `FPSU_OP_CMP, {1'b1, `FPSU_CMP_LT},
            pack_singles(2'b00, qnan, qnan),
            pack_singles(2'b00, 32'h3f80_0000, 32'h3f80_0000), 0, 0, 32'h0);
    add_row("fwd_seed", 1, `FPSU_OP_XOR, 0, rand_word(), rand_word(), 0, 0, 32'h0);
    add_row("fwd_a", 1, `FPSU_OP_OR, 0, rand_word(), rand_word(), 1, 0, 32'h0);
    add_row("fwd_b", 1, `FPSU_OP_ANDN, 0, rand_word(), rand_word(), 0, 1, 32'h0);
    add_row("fwd_chain", 1, `FPSU_OP_XOR, 0, rand_word(), rand_word(), 1, 0, 32'h0);
    add_row("idle", 0, 0, 0, rand_word(), rand_word(), 0, 0, 32'h0);
    add_row("fwd_after_idle", 1, `FPSU_OP_PERM, `FPSU_PERM_SWAP, rand_word(), rand_word(), 1, 0,
            32'h0);
    add_row("idle", 0, 0, 0, rand_word(), rand_word(), 0, 0, 32'h0);
    add_row("idle", 0, 0, 0, rand_word(), rand_word(), 0, 0, 32'h0);
    add_row("fwd_both", 1, `FPSU_OP_AND, 0, rand_word(), rand_word(), 1, 1, 32'h0);
    limit = 10 + nrows + 20;

    repeat (10) begin
      @(posedge clk);
      #1;
      if (res_valid !== 1'b0 || ret_en !== 1'b0 || cmp_flags !== '0 || res_data !== '0) begin
        $display("outputs not cleared during reset");
        other_errors++;
      end
    end
    rst = 1'b0;

    for (int i = 0; i < nrows; i++) begin
      run_row(tbl_req[i], tbl_csr[i], tbl_name[i]);
    end
    // drain the pipeline
    repeat (3) run_row(idle, 32'h0, "drain");

    $display("errors: mismatches %0d, other %0d", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+include
logic/fpsu_pkg.sv
logic/fpsu_issue_stage.sv
logic/fpsu_operand_stage.sv
logic/fpsu_compare.sv
logic/fpsu_execute_stage.sv
logic/fpsu_top.sv
bench/fpsu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fpsu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module fpsu_tb -o fpsu_sim

out=$(./obj_dir/fpsu_sim)
echo "$out"

# exit status comes from the search
echo "$out" | grep -q "All tests passed"
